/* list.f */
verilog/uart_pkg.sv
verilog/frame_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/frame_tx.sv
verilog/frame_rx.sv
verilog/uart_frame_top.sv
tests/tb_clk.sv
tests/uart_frame_chk.sv
tests/tb_uart_frame.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_uart_frame -f list.f -o tb_uart_frame

status=0
output=$(./obj_dir/tb_uart_frame 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

/* tests/tb_uart_frame.sv */
//====================
// uart framer testbench
// loopback and raw-line cases from a table,
// with a decoder on the transmit line
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_uart_frame;
	import uart_pkg::*;
	import frame_pkg::*;

	localparam int num_entries = 10;
	localparam int max_raw = 24;

	typedef struct packed {
		logic raw_mode;
		logic busy_poke;
		logic want_frame;
		int raw_len;
		int bad_stop;
		frame_t frame;
		frame_t want;
	} entry_t;

	logic sys_clk;
	logic sys_rst_n;
	logic tx_req;
	frame_t tx_frame;
	logic uart_rx_port;
	logic tx_busy;
	logic tx_done;
	logic rx_busy;
	logic rx_done;
	frame_t rx_frame;
	logic uart_tx_port;

	// receive line source, raw driver or loopback
	logic use_raw;
	logic raw_line;

	entry_t tbl [0:num_entries-1];
	uart_byte_t raw_tbl [0:num_entries-1][0:max_raw-1];
	logic [31:0] rng_state;
	uart_byte_t byte_q [$];
	int tx_done_cnt;
	int rx_done_cnt;
	time last_tx_time;
	time last_rx_time;
	longint budget_ns;
	// rx_busy one cycle back
	logic rx_busy_prev;

	tb_clk u_clk (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n)
	);

	uart_frame_top DUT (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tx_req(tx_req),
		.tx_frame(tx_frame),
		.uart_rx_port(uart_rx_port),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.rx_busy(rx_busy),
		.rx_done(rx_done),
		.rx_frame(rx_frame),
		.uart_tx_port(uart_tx_port)
	);

	bind uart_frame_top uart_frame_chk u_chk (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.rx_done(rx_done),
		.rx_frame(rx_frame),
		.uart_tx_port(uart_tx_port)
	);

	assign uart_rx_port = use_raw ? raw_line : uart_tx_port;

	task automatic stop_on_error();
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_frame(input frame_t got, input frame_t exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t: %s, expected len %0d payload %h", $time, what,
				exp.len, exp.payload);
			$display("   got len %0d payload %h", got.len, got.payload);
			stop_on_error();
		end
	endtask

	task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t: %s, expected %h got %h", $time, what, exp, got);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t: %s, expected %b got %b", $time, what, exp, got);
			stop_on_error();
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// printable, never the marker
	function automatic uart_byte_t next_char();
		uart_byte_t c;
		rng_state = xorshift(rng_state);
		c = uart_byte_t'(33 + rng_state % 94);
		if (c == frame_marker)
			c = "a";
		return c;
	endfunction

	// bytes at or above len come back as zero
	function automatic entry_t make_loopback(input int len, input logic poke);
		entry_t e;
		int i;
		e = '0;
		e.busy_poke = poke;
		e.bad_stop = -1;
		e.want_frame = 1'b1;
		e.frame.len = frame_len_t'(len);
		e.want.len = frame_len_t'(len);
		for (i = 0; i < max_chars; i++) begin
			e.frame.payload[8*i +: 8] = next_char();
			if (i < len)
				e.want.payload[8*i +: 8] = e.frame.payload[8*i +: 8];
		end
		return e;
	endfunction

	task automatic put_raw(input int n, input uart_byte_t b);
		raw_tbl[n][tbl[n].raw_len] = b;
		tbl[n].raw_len = tbl[n].raw_len + 1;
	endtask

	task automatic put_markers(input int n);
		put_raw(n, frame_marker);
		put_raw(n, frame_marker);
	endtask

	// content byte the receiver should report
	task automatic put_content(input int n);
		uart_byte_t b;
		b = next_char();
		tbl[n].want.payload[8*tbl[n].want.len +: 8] = b;
		tbl[n].want.len = tbl[n].want.len + 1'b1;
		put_raw(n, b);
	endtask

	task automatic start_raw(input int n, input logic want);
		tbl[n] = '0;
		tbl[n].raw_mode = 1'b1;
		tbl[n].want_frame = want;
		tbl[n].bad_stop = -1;
	endtask

	task automatic build_table();
		int i;
		tbl[0] = make_loopback(0, 1'b0);
		tbl[1] = make_loopback(1, 1'b0);
		tbl[2] = make_loopback(5, 1'b0);
		tbl[3] = make_loopback(max_chars, 1'b0);
		// second request lands while the first frame is on the line
		tbl[4] = make_loopback(3, 1'b1);
		// garbage and a lone marker ahead of a good frame
		start_raw(5, 1'b1);
		put_raw(5, "x");
		put_raw(5, "y");
		put_raw(5, "z");
		put_raw(5, frame_marker);
		put_raw(5, "Q");
		put_markers(5);
		for (i = 0; i < 4; i++)
			put_content(5);
		put_markers(5);
		// one content byte too many
		start_raw(6, 1'b0);
		put_markers(6);
		for (i = 0; i <= max_chars; i++)
			put_raw(6, next_char());
		put_markers(6);
		// lone marker inside the body
		start_raw(7, 1'b0);
		put_markers(7);
		put_raw(7, "a");
		put_raw(7, "b");
		put_raw(7, frame_marker);
		put_raw(7, "x");
		put_raw(7, "c");
		put_markers(7);
		tbl[8] = make_loopback(7, 1'b0);
		// middle character has a low stop bit and must vanish
		start_raw(9, 1'b1);
		put_markers(9);
		put_content(9);
		put_content(9);
		tbl[9].bad_stop = tbl[9].raw_len;
		put_raw(9, next_char());
		put_content(9);
		put_content(9);
		put_markers(9);
	endtask

	// called a step after a rising edge
	task automatic send_char(input uart_byte_t c, input logic stop_bit);
		int i;
		raw_line = 1'b0;
		repeat (clks_per_bit) @(posedge sys_clk);
		#1;
		for (i = 0; i < 8; i++) begin
			raw_line = c[i];
			repeat (clks_per_bit) @(posedge sys_clk);
			#1;
		end
		raw_line = stop_bit;
		repeat (clks_per_bit) @(posedge sys_clk);
		#1;
		// idle bit, gives a start edge even after a low stop bit
		raw_line = 1'b1;
		repeat (clks_per_bit) @(posedge sys_clk);
		#1;
	endtask

	task automatic send_frame_loopback(input int n);
		int tx0;
		int rx0;
		int len;
		int i;
		uart_byte_t exp;
		tx0 = tx_done_cnt;
		rx0 = rx_done_cnt;
		len = int'(tbl[n].frame.len);
		byte_q.delete();
		@(posedge sys_clk);
		#1;
		use_raw = 1'b0;
		tx_req = 1'b1;
		tx_frame = tbl[n].frame;
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
		if (tbl[n].busy_poke) begin
			repeat (2 * clks_per_bit) @(posedge sys_clk);
			#1;
			check_flag(tx_busy, 1'b1, "tx_busy while sending");
			tx_req = 1'b1;
			tx_frame.len = frame_len_t'(max_chars);
			tx_frame.payload = ~tx_frame.payload;
			@(posedge sys_clk);
			#1;
			tx_req = 1'b0;
		end
		wait (tx_done_cnt != tx0);
		@(negedge sys_clk);
		check_flag(tx_busy, 1'b0, "tx_busy after tx_done");
		// room for any extra frame to show up
		repeat (4 * clks_per_bit) @(negedge sys_clk);
		check_flag(tx_done_cnt == tx0 + 1, 1'b1, "one tx_done per request");
		check_flag(rx_done_cnt == rx0 + 1, 1'b1, "one rx_done per frame");
		check_flag(last_rx_time < last_tx_time, 1'b1, "rx_done ahead of tx_done");
		check_frame(rx_frame, tbl[n].want, "loopback frame");
		check_flag(byte_q.size() == len + 4, 1'b1, "character count on uart_tx_port");
		for (i = 0; i < len + 4; i++) begin
			if (i >= 2 && i < len + 2)
				exp = tbl[n].frame.payload[8*(i-2) +: 8];
			else
				exp = frame_marker;
			check_byte(byte_q[i], exp, "character on uart_tx_port");
		end
	endtask

	task automatic play_raw_stream(input int n);
		int rx0;
		int i;
		rx0 = rx_done_cnt;
		@(posedge sys_clk);
		#1;
		use_raw = 1'b1;
		for (i = 0; i < tbl[n].raw_len; i++)
			send_char(raw_tbl[n][i], i != tbl[n].bad_stop);
		repeat (4) @(negedge sys_clk);
		check_flag(rx_busy, 1'b0, "rx_busy after the stream");
		if (tbl[n].want_frame) begin
			check_flag(rx_done_cnt == rx0 + 1, 1'b1, "one rx_done for the stream");
			check_frame(rx_frame, tbl[n].want, "frame from raw stream");
		end else begin
			check_flag(rx_done_cnt == rx0, 1'b1, "no rx_done for a broken frame");
		end
	endtask

	// done strobe counters
	always @(negedge sys_clk) begin
		if (tx_done === 1'b1) begin
			tx_done_cnt = tx_done_cnt + 1;
			last_tx_time = $time;
		end
		if (rx_done === 1'b1) begin
			// frame still open while its closing marker arrives
			check_flag(rx_busy_prev, 1'b1, "rx_busy ahead of rx_done");
			rx_done_cnt = rx_done_cnt + 1;
			last_rx_time = $time;
		end
		rx_busy_prev = rx_busy;
	end

	// transmit line decoder, mid-bit samples
	initial begin : line_decoder
		uart_byte_t c;
		int i;
		wait (sys_rst_n === 1'b1);
		forever begin
			@(negedge uart_tx_port);
			repeat (half_bit) @(negedge sys_clk);
			for (i = 0; i < 8; i++) begin
				repeat (clks_per_bit) @(negedge sys_clk);
				c[i] = uart_tx_port;
			end
			repeat (clks_per_bit) @(negedge sys_clk);
			check_flag(uart_tx_port, 1'b1, "stop bit on uart_tx_port");
			byte_q.push_back(c);
		end
	end

	initial begin : watchdog
		wait (budget_ns != 0);
		#(budget_ns);
		$display("timeout, the tests did not finish within %0d ns", budget_ns);
		stop_on_error();
	end

	initial begin : main
		int n;
		int chars;
		longint b;
		tx_req = 1'b0;
		tx_frame = '0;
		use_raw = 1'b0;
		raw_line = 1'b1;
		tx_done_cnt = 0;
		rx_done_cnt = 0;
		last_tx_time = 0;
		last_rx_time = 0;
		rx_busy_prev = 1'b0;
		rng_state = 32'hd3ba;
		build_table();
		b = 2000;
		for (n = 0; n < num_entries; n++) begin
			chars = tbl[n].raw_mode ? tbl[n].raw_len : 4 + int'(tbl[n].frame.len);
			b = b + longint'(chars + 8) * 10 * clks_per_bit * 10;
		end
		budget_ns = b;
		wait (sys_rst_n === 1'b1);
		@(negedge sys_clk);
		check_flag(uart_tx_port, 1'b1, "uart_tx_port after reset");
		check_flag(tx_busy, 1'b0, "tx_busy after reset");
		check_flag(tx_done, 1'b0, "tx_done after reset");
		check_flag(rx_busy, 1'b0, "rx_busy after reset");
		check_flag(rx_done, 1'b0, "rx_done after reset");
		check_frame(rx_frame, '0, "rx_frame after reset");
		for (n = 0; n < num_entries; n++) begin
			if (tbl[n].raw_mode)
				play_raw_stream(n);
			else
				send_frame_loopback(n);
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/uart_frame_chk.sv */
//====================
// framer port checks
// strobe widths, busy and idle line rules
//====================
`timescale 1ns/1ps
`default_nettype none

module uart_frame_chk (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire tx_busy,
	input wire tx_done,
	input wire rx_done,
	input wire frame_pkg::frame_t rx_frame,
	input wire uart_tx_port
);
	import frame_pkg::*;

	// done strobes are single cycle
	tx_done_pulse: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) tx_done |=> !tx_done
	) else $error("tx_done high for more than one cycle");

	rx_done_pulse: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) rx_done |=> !rx_done
	) else $error("rx_done high for more than one cycle");

	tx_done_in_frame: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) tx_done |-> tx_busy
	) else $error("tx_done outside a frame");

	// line idles high between frames
	idle_line_high: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) !tx_busy |-> uart_tx_port
	) else $error("uart_tx_port low while idle");

	rx_len_range: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n) rx_frame.len <= frame_len_t'(max_chars)
	) else $error("rx_frame.len above capacity");

endmodule

`default_nettype wire

/* tests/tb_clk.sv */
//====================
// testbench clock and reset
// 10 ns clock, reset low for 4 cycles
//====================
`timescale 1ns/1ps
`default_nettype none

module tb_clk (
	output logic sys_clk,
	output logic sys_rst_n
);
	localparam int half_period = 5;
	localparam int rst_cycles = 4;

	initial begin
		sys_clk = 1'b0;
		forever #(half_period) sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (rst_cycles) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/uart_frame_top.sv */
//====================
// uart string framer
// transmit and receive framing pipelines
//====================
`timescale 1ns/1ps
`default_nettype none

module uart_frame_top (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire tx_req,
	input wire frame_pkg::frame_t tx_frame,
	input wire uart_rx_port,
	output logic tx_busy,
	output logic tx_done,
	output logic rx_busy,
	output logic rx_done,
	output frame_pkg::frame_t rx_frame,
	output logic uart_tx_port
);
	import uart_pkg::*;

	// frame_tx to uart_tx
	logic byte_stb;
	logic byte_done;
	uart_byte_t byte_data;

	// uart_rx to frame_rx
	logic rx_stb;
	uart_byte_t rx_byte;

	frame_tx u_frame_tx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tx_req(tx_req),
		.tx_frame(tx_frame),
		.byte_done(byte_done),
		.tx_busy(tx_busy),
		.tx_done(tx_done),
		.byte_stb(byte_stb),
		.byte_data(byte_data)
	);

	uart_tx u_uart_tx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.byte_stb(byte_stb),
		.byte_data(byte_data),
		.line(uart_tx_port),
		.byte_done(byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.line(uart_rx_port),
		.rx_stb(rx_stb),
		.rx_byte(rx_byte)
	);

	frame_rx u_frame_rx (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.rx_stb(rx_stb),
		.rx_byte(rx_byte),
		.rx_frame(rx_frame),
		.rx_busy(rx_busy),
		.rx_done(rx_done)
	);

endmodule

`default_nettype wire

/* verilog/frame_rx.sv */
//====================
// frame receiver
// finds && payload && in the byte stream,
// drops overlong or broken frames
//====================
`timescale 1ns/1ps
`default_nettype none

module frame_rx (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire rx_stb,
	input wire uart_pkg::uart_byte_t rx_byte,
	output frame_pkg::frame_t rx_frame,
	output logic rx_busy,
	output logic rx_done
);
	import frame_pkg::*;

	frame_rx_state_t state;
	frame_payload_t coll;
	frame_len_t cnt;
	// set after a discard: the next marker pair closes the bad frame
	logic skip;
	logic is_marker;
	logic full;

	assign is_marker = (rx_byte == frame_marker);
	assign full = (cnt == frame_len_t'(max_chars));
	assign rx_busy = (state == rx_body) || (state == rx_close2);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= rx_hunt;
			cnt <= '0;
			skip <= 1'b0;
			rx_done <= 1'b0;
			rx_frame <= '0;
		end else begin
			rx_done <= 1'b0;
			if (rx_stb) begin
				case (state)
					rx_hunt: begin
						if (is_marker)
							state <= rx_open2;
					end
					rx_open2: begin
						if (is_marker && !skip) begin
							state <= rx_body;
							cnt <= '0;
						end else begin
							state <= rx_hunt;
							if (is_marker)
								skip <= 1'b0;
						end
					end
					rx_body: begin
						if (is_marker) begin
							state <= rx_close2;
						end else if (full) begin
							// 17th content byte
							state <= rx_hunt;
							skip <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
					rx_close2: begin
						if (is_marker) begin
							rx_frame.payload <= coll;
							rx_frame.len <= cnt;
							rx_done <= 1'b1;
						end else begin
							// lone marker inside the content
							skip <= 1'b1;
						end
						state <= rx_hunt;
					end
					default: state <= rx_hunt;
				endcase
			end
		end
	end

	// collection buffer, cleared on the second opening marker
	always_ff @(posedge sys_clk) begin
		if (rx_stb) begin
			if (state == rx_open2 && is_marker)
				coll <= '0;
			else if (state == rx_body && !is_marker && !full)
				coll[8*cnt +: 8] <= rx_byte;
		end
	end

endmodule

`default_nettype wire

/* verilog/frame_tx.sv */
//====================
// frame transmitter
// sends && payload && for one accepted
// request, one character at a time
//====================
`timescale 1ns/1ps
`default_nettype none

module frame_tx (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire tx_req,
	input wire frame_pkg::frame_t tx_frame,
	input wire byte_done,
	output logic tx_busy,
	output logic tx_done,
	output logic byte_stb,
	output uart_pkg::uart_byte_t byte_data
);
	import frame_pkg::*;

	frame_tx_state_t state;
	frame_tx_state_t state_n;
	frame_t frame_q;
	// index of the payload byte in flight
	frame_len_t idx;
	frame_len_t idx_n;
	logic send;
	logic accept;

	assign accept = (state == tx_idle) && tx_req;
	assign tx_busy = (state != tx_idle);
	assign tx_done = (state == tx_close2) && byte_done;

	always_comb begin
		state_n = state;
		idx_n = idx;
		send = 1'b0;
		case (state)
			tx_idle: begin
				if (tx_req) begin
					state_n = tx_open1;
					send = 1'b1;
				end
			end
			tx_open1: begin
				if (byte_done) begin
					state_n = tx_open2;
					send = 1'b1;
				end
			end
			tx_open2: begin
				// empty payload goes straight to the closing pair
				if (byte_done) begin
					send = 1'b1;
					idx_n = '0;
					state_n = (frame_q.len == '0) ? tx_close1 : tx_body;
				end
			end
			tx_body: begin
				if (byte_done) begin
					send = 1'b1;
					if (idx + 1'b1 == frame_q.len)
						state_n = tx_close1;
					else
						idx_n = idx + 1'b1;
				end
			end
			tx_close1: begin
				if (byte_done) begin
					state_n = tx_close2;
					send = 1'b1;
				end
			end
			tx_close2: begin
				if (byte_done)
					state_n = tx_idle;
			end
			default: state_n = tx_idle;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= tx_idle;
			idx <= '0;
			byte_stb <= 1'b0;
		end else begin
			state <= state_n;
			idx <= idx_n;
			byte_stb <= send;
		end
	end

	// request latch and outgoing character
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			frame_q.payload <= tx_frame.payload;
			if (tx_frame.len > frame_len_t'(max_chars))
				frame_q.len <= frame_len_t'(max_chars);
			else
				frame_q.len <= tx_frame.len;
		end
		if (send) begin
			if (state_n == tx_body)
				byte_data <= frame_q.payload[8*idx_n +: 8];
			else
				byte_data <= frame_marker;
		end
	end

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
//====================
// uart receiver
// samples 8N1 characters at mid-bit and
// strobes each one with a valid stop bit
//====================
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire line,
	output logic rx_stb,
	output uart_pkg::uart_byte_t rx_byte
);
	import uart_pkg::*;

	logic sync1;
	logic sync2;
	logic sync_prev;
	logic active;
	logic fall;
	logic at_half;
	logic at_full;
	baud_cnt_t baud_cnt;
	bit_cnt_t bit_cnt;
	uart_byte_t shreg;

	assign fall = sync_prev & ~sync2;
	assign at_half = (baud_cnt == baud_cnt_t'(half_bit - 1));
	assign at_full = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

	// stable during the stop bit, so valid with rx_stb
	assign rx_byte = shreg;

	// two-flop synchronizer plus one stage of edge history
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync1 <= 1'b1;
			sync2 <= 1'b1;
			sync_prev <= 1'b1;
		end else begin
			sync1 <= line;
			sync2 <= sync1;
			sync_prev <= sync2;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			rx_stb <= 1'b0;
		end else begin
			rx_stb <= 1'b0;
			if (!active) begin
				if (fall) begin
					active <= 1'b1;
					baud_cnt <= '0;
					bit_cnt <= '0;
				end
			end else if (bit_cnt == '0) begin
				// middle of the start bit, drop glitches
				if (at_half) begin
					baud_cnt <= '0;
					if (sync2)
						active <= 1'b0;
					else
						bit_cnt <= 4'd1;
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end else if (at_full) begin
				baud_cnt <= '0;
				if (bit_cnt == bit_cnt_t'(stop_idx)) begin
					// framing error: stop bit low, character dropped
					active <= 1'b0;
					rx_stb <= sync2;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge sys_clk) begin
		if (active && at_full && bit_cnt != '0 && bit_cnt != bit_cnt_t'(stop_idx))
			shreg <= {sync2, shreg[7:1]};
	end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
//====================
// uart transmitter
// sends one 8N1 character per strobe,
// LSB first, line idles high
//====================
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire byte_stb,
	input wire uart_pkg::uart_byte_t byte_data,
	output logic line,
	output logic byte_done
);
	import uart_pkg::*;

	logic busy;
	logic bit_end;
	baud_cnt_t baud_cnt;
	bit_cnt_t bit_cnt;
	// remaining data bits with the stop bit behind them
	logic [8:0] shreg;

	assign bit_end = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
			line <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				// start bit goes out right away
				if (byte_stb) begin
					busy <= 1'b1;
					baud_cnt <= '0;
					bit_cnt <= '0;
					line <= 1'b0;
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				if (bit_cnt == bit_cnt_t'(stop_idx)) begin
					// stop bit finished, line already high
					busy <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					line <= shreg[0];
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// character shifter
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_stb)
			shreg <= {1'b1, byte_data};
		else if (busy && bit_end)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

`default_nettype wire

/* verilog/frame_pkg.sv */
//====================
// frame package
// payload, length and marker definitions
// plus the framer state encodings
//====================
`default_nettype none

package frame_pkg;

	// payload capacity in characters
	localparam int max_chars = 16;

	// "&", sent twice before and twice after the payload
	localparam uart_pkg::uart_byte_t frame_marker = 8'h26;

	// byte 0 sits in the low 8 bits
	typedef logic [max_chars*8-1:0] frame_payload_t;

	// 0 to 16 characters
	typedef logic [4:0] frame_len_t;

	typedef struct packed {
		frame_payload_t payload;
		frame_len_t len;
	} frame_t;

	// transmit sequencer
	typedef enum logic [2:0] {
		tx_idle,
		tx_open1,
		tx_open2,
		tx_body,
		tx_close1,
		tx_close2
	} frame_tx_state_t;

	// receive parser
	typedef enum logic [1:0] {
		rx_hunt,
		rx_open2,
		rx_body,
		rx_close2
	} frame_rx_state_t;

endpackage

`default_nettype wire

/* verilog/uart_pkg.sv */
//====================
// uart line package
// bit timing and character types shared
// by the serializer and the deserializer
//====================
`default_nettype none

package uart_pkg;

	// sys_clk cycles per bit time, kept short for simulation
	localparam int clks_per_bit = 16;

	// mid-bit sampling point
	localparam int half_bit = clks_per_bit / 2;

	// bit index of the stop bit; start is 0, data 1..8
	localparam int stop_idx = 9;

	// one character on the line
	typedef logic [7:0] uart_byte_t;

	// position within a character, start through stop
	typedef logic [3:0] bit_cnt_t;

	// clocks within one bit time
	typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;

endpackage

`default_nettype wire
